// File: source/scrmbl_cfg.svh
`ifndef SCRMBL_CFG_SVH
`define SCRMBL_CFG_SVH

// geometry of the PRESENT-128 core and of the scrambler around it
`define SCRMBL_BLOCK_W 64
`define SCRMBL_KEY_W 128
`define SCRMBL_NUM_ROUNDS 31
`define SCRMBL_NUM_KEYS 4
`define SCRMBL_NUM_DIGEST_SETS 2

// encryption key table, key 0 stays all zero so that the textbook vector can be reproduced
`define SCRMBL_KEY_0 128'h0000_0000_0000_0000_0000_0000_0000_0000
`define SCRMBL_KEY_1 128'h3ba0_7c5e_19d4_f2a8_6e01_b7c3_9d52_48fa
`define SCRMBL_KEY_2 128'hc4e1_9a07_5bd3_2f68_e0a9_17c4_b25d_830f
`define SCRMBL_KEY_3 128'h7f2d_e608_a1b4_5c93_0e7a_d85f_16c2_b94e

// initial chaining values of the Merkle-Damgard digest, one per set
`define SCRMBL_DIGEST_IV_0 64'h90c7_f21f_6224_f027
`define SCRMBL_DIGEST_IV_1 64'h4b3a_58de_7c01_96e5

// keys used by the finalization step, one per set
`define SCRMBL_DIGEST_CONST_0 128'hf98c_48b1_f937_7284_4a25_e5d1_c5e8_1a07
`define SCRMBL_DIGEST_CONST_1 128'h2d5e_0b91_c7a3_6f48_e1d0_8b27_5a9c_34f6

`endif

// File: source/scrmbl_pkg.sv
`default_nettype none

`include "scrmbl_cfg.svh"

package scrmbl_pkg;

  // data words of the scrambler
  typedef logic [`SCRMBL_BLOCK_W-1:0] block_t;
  typedef logic [`SCRMBL_KEY_W-1:0] key_t;
  typedef logic [$clog2(`SCRMBL_NUM_KEYS)-1:0] sel_t;
  // wide enough to hold the round count itself
  typedef logic [$clog2(`SCRMBL_NUM_ROUNDS + 1)-1:0] round_idx_t;

  // commands seen on cmd_i
  typedef enum logic [2:0] {
    CmdEncrypt        = 3'd0,
    CmdLoadShadow     = 3'd1,
    CmdDigestInit     = 3'd2,
    CmdDigest         = 3'd3,
    CmdDigestFinalize = 3'd4
  } scrmbl_cmd_e;

  // source of the next key register value
  typedef enum logic [1:0] {KeyRound, KeyTable, KeyDigestInput, KeyDigestConst} key_sel_e;

  // source of the next data register value
  typedef enum logic [1:0] {DataRound, DataRoundXor, DataDigestState, DataInput} data_sel_e;

  typedef enum logic [1:0] {StIdle, StEncrypt, StDigest} ctrl_state_e;

endpackage

`default_nettype wire

// File: source/present_round.sv
`default_nettype none

`include "scrmbl_cfg.svh"

module present_round (
  input  wire scrmbl_pkg::block_t     data_i,
  input  wire scrmbl_pkg::key_t       key_i,
  input  wire scrmbl_pkg::round_idx_t idx_i,
  output scrmbl_pkg::block_t          data_o,
  output scrmbl_pkg::key_t            key_o,
  output scrmbl_pkg::round_idx_t      idx_o
);

  import scrmbl_pkg::*;

  // the last round also adds the final whitening key
  localparam round_idx_t last_round = round_idx_t'(`SCRMBL_NUM_ROUNDS);
  localparam int num_nibbles = `SCRMBL_BLOCK_W / 4;

  // 4-bit PRESENT S-box
  function automatic logic [3:0] sbox4(input logic [3:0] x);
    logic [3:0] y;
    case (x)
      4'h0: y = 4'hc;
      4'h1: y = 4'h5;
      4'h2: y = 4'h6;
      4'h3: y = 4'hb;
      4'h4: y = 4'h9;
      4'h5: y = 4'h0;
      4'h6: y = 4'ha;
      4'h7: y = 4'hd;
      4'h8: y = 4'h3;
      4'h9: y = 4'he;
      4'ha: y = 4'hf;
      4'hb: y = 4'h8;
      4'hc: y = 4'h4;
      4'hd: y = 4'h7;
      4'he: y = 4'h1;
      default: y = 4'h2;
    endcase
    return y;
  endfunction

  // bit i moves to position 16*i mod 63, bit 63 stays in place
  function automatic block_t perm_layer(input block_t x);
    block_t y;
    y = '0;
    for (int i = 0; i < `SCRMBL_BLOCK_W - 1; i++) begin
      y[(i * 16) % (`SCRMBL_BLOCK_W - 1)] = x[i];
    end
    y[`SCRMBL_BLOCK_W-1] = x[`SCRMBL_BLOCK_W-1];
    return y;
  endfunction

  block_t add_key;
  block_t sub_out;
  block_t perm_out;
  key_t   key_rot;

  //////////////////////////////////////////////////////////////////////
  // data path of one round

  always_comb begin
    // round key is the upper half of the key register
    add_key = data_i ^ key_i[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];
    for (int n = 0; n < num_nibbles; n++) begin
      sub_out[4*n +: 4] = sbox4(add_key[4*n +: 4]);
    end
    perm_out = perm_layer(sub_out);
  end

  //////////////////////////////////////////////////////////////////////
  // key schedule step

  always_comb begin
    // rotate left by 61
    key_rot = {key_i[66:0], key_i[`SCRMBL_KEY_W-1:67]};
    key_o = key_rot;
    // only the top two nibbles pass through the S-box in the 128-bit schedule
    key_o[127:124] = sbox4(key_rot[127:124]);
    key_o[123:120] = sbox4(key_rot[123:120]);
    // round counter is mixed into the middle of the key
    key_o[66:62] = key_rot[66:62] ^ idx_i;
  end

  assign idx_o = idx_i + round_idx_t'(1);

  // after the last round the next round key whitens the state
  assign data_o = (idx_i == last_round) ? perm_out ^ key_o[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W]
                                        : perm_out;

endmodule

`default_nettype wire

// File: source/scrmbl_datapath.sv
`default_nettype none

`include "scrmbl_cfg.svh"

module scrmbl_datapath (
  input  wire                         clk_i,
  input  wire                         rst_ni,
  input  wire scrmbl_pkg::sel_t       sel_i,
  input  wire scrmbl_pkg::block_t     data_i,
  input  wire scrmbl_pkg::key_sel_e   key_sel_i,
  input  wire scrmbl_pkg::data_sel_e  data_sel_i,
  input  wire                         key_en_i,
  input  wire                         data_en_i,
  input  wire                         shadow_en_i,
  input  wire                         digest_en_i,
  input  wire                         digest_init_i,
  input  wire                         out_valid_i,
  output scrmbl_pkg::round_idx_t      round_idx_o,
  output scrmbl_pkg::block_t          data_o
);

  import scrmbl_pkg::*;

  localparam int digest_sel_w = $clog2(`SCRMBL_NUM_DIGEST_SETS);

  //////////////////////////////////////////////////////////////////////
  // constant tables

  localparam key_t enc_key_lut [`SCRMBL_NUM_KEYS] = '{
    `SCRMBL_KEY_0, `SCRMBL_KEY_1, `SCRMBL_KEY_2, `SCRMBL_KEY_3
  };
  localparam key_t digest_const_lut [`SCRMBL_NUM_DIGEST_SETS] = '{
    `SCRMBL_DIGEST_CONST_0, `SCRMBL_DIGEST_CONST_1
  };
  localparam block_t digest_iv_lut [`SCRMBL_NUM_DIGEST_SETS] = '{
    `SCRMBL_DIGEST_IV_0, `SCRMBL_DIGEST_IV_1
  };

  logic [digest_sel_w-1:0] digest_sel;

  // working registers and their next values
  key_t       key_q, key_d;
  round_idx_t idx_q, idx_d;
  block_t     data_q, data_d;
  block_t     shadow_q;
  block_t     digest_q, digest_d;
  block_t     out_q;

  // outputs of the round function
  block_t     round_data;
  block_t     round_data_xor;
  key_t       round_key;
  round_idx_t round_idx_next;

  // the digest sets only need the low selector bits
  assign digest_sel = sel_i[digest_sel_w-1:0];

  present_round u_round (
    .data_i (data_q),
    .key_i  (key_q),
    .idx_i  (idx_q),
    .data_o (round_data),
    .key_o  (round_key),
    .idx_o  (round_idx_next)
  );

  // Davies-Meyer feed-forward of the chaining value
  assign round_data_xor = round_data ^ digest_q;

  //////////////////////////////////////////////////////////////////////
  // next state muxes

  always_comb begin
    unique case (key_sel_i)
      KeyRound:       key_d = round_key;
      KeyTable:       key_d = enc_key_lut[sel_i];
      // message block is the new data word on top of the shadowed one
      KeyDigestInput: key_d = {data_i, shadow_q};
      default:        key_d = digest_const_lut[digest_sel];
    endcase
  end

  // every fresh key starts the schedule at round one
  assign idx_d = (key_sel_i == KeyRound) ? round_idx_next : round_idx_t'(1);

  always_comb begin
    unique case (data_sel_i)
      DataRound:       data_d = round_data;
      DataRoundXor:    data_d = round_data_xor;
      DataDigestState: data_d = digest_q;
      default:         data_d = data_i;
    endcase
  end

  assign digest_d = digest_init_i ? digest_iv_lut[digest_sel] : round_data_xor;

  //////////////////////////////////////////////////////////////////////
  // registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q    <= '0;
      idx_q    <= '0;
      data_q   <= '0;
      shadow_q <= '0;
      digest_q <= '0;
      out_q    <= '0;
    end else begin
      if (key_en_i) begin
        key_q <= key_d;
        idx_q <= idx_d;
      end
      if (data_en_i) begin
        data_q <= data_d;
      end
      if (shadow_en_i) begin
        shadow_q <= data_i;
      end
      if (digest_en_i) begin
        digest_q <= digest_d;
      end
      // the result is only visible for one cycle and the output is zero otherwise
      out_q <= out_valid_i ? data_q : '0;
    end
  end

  assign round_idx_o = idx_q;
  assign data_o      = out_q;

  // constant and IV selectors must point into the digest tables
  digest_sel_range_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((key_en_i && key_sel_i == KeyDigestConst) || (digest_en_i && digest_init_i))
      |-> int'(sel_i) < `SCRMBL_NUM_DIGEST_SETS);

endmodule

`default_nettype wire

// File: source/scrmbl_ctrl.sv
`default_nettype none

`include "scrmbl_cfg.svh"

module scrmbl_ctrl (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire scrmbl_pkg::scrmbl_cmd_e cmd_i,
  input  wire                          valid_i,
  input  wire scrmbl_pkg::round_idx_t  round_idx_i,
  output logic                         ready_o,
  output scrmbl_pkg::key_sel_e         key_sel_o,
  output scrmbl_pkg::data_sel_e        data_sel_o,
  output logic                         key_en_o,
  output logic                         data_en_o,
  output logic                         shadow_en_o,
  output logic                         digest_en_o,
  output logic                         digest_init_o,
  output logic                         out_valid_o
);

  import scrmbl_pkg::*;

  // round index seen by the datapath while it computes the final round
  localparam round_idx_t last_round = round_idx_t'(`SCRMBL_NUM_ROUNDS);

  ctrl_state_e state_q, state_d;
  // set once the last round has been written back
  logic done_q, done_d;

  //////////////////////////////////////////////////////////////////////
  // FSM

  always_comb begin
    state_d       = state_q;
    done_d        = done_q;
    ready_o       = 1'b0;
    key_sel_o     = KeyRound;
    data_sel_o    = DataRound;
    key_en_o      = 1'b0;
    data_en_o     = 1'b0;
    shadow_en_o   = 1'b0;
    digest_en_o   = 1'b0;
    digest_init_o = 1'b0;
    out_valid_o   = 1'b0;

    unique case (state_q)
      StIdle: begin
        ready_o = 1'b1;
        if (valid_i) begin
          case (cmd_i)
            CmdEncrypt: begin
              state_d    = StEncrypt;
              key_sel_o  = KeyTable;
              data_sel_o = DataInput;
              key_en_o   = 1'b1;
              data_en_o  = 1'b1;
            end
            CmdLoadShadow: begin
              shadow_en_o = 1'b1;
            end
            CmdDigestInit: begin
              digest_init_o = 1'b1;
              digest_en_o   = 1'b1;
            end
            // the chaining value is encrypted under the 128-bit message block
            CmdDigest: begin
              state_d    = StDigest;
              key_sel_o  = KeyDigestInput;
              data_sel_o = DataDigestState;
              key_en_o   = 1'b1;
              data_en_o  = 1'b1;
            end
            CmdDigestFinalize: begin
              state_d    = StDigest;
              key_sel_o  = KeyDigestConst;
              data_sel_o = DataDigestState;
              key_en_o   = 1'b1;
              data_en_o  = 1'b1;
            end
            // unknown opcodes are accepted and dropped
            default: begin
              state_d = StIdle;
            end
          endcase
        end
      end

      StEncrypt, StDigest: begin
        if (done_q) begin
          // the data register holds the result, hand it to the output register
          out_valid_o = 1'b1;
          done_d      = 1'b0;
          state_d     = StIdle;
        end else begin
          key_en_o  = 1'b1;
          data_en_o = 1'b1;
          if (round_idx_i == last_round) begin
            done_d = 1'b1;
            // a digest update closes with the feed-forward and keeps the new chaining value
            if (state_q == StDigest) begin
              data_sel_o  = DataRoundXor;
              digest_en_o = 1'b1;
            end
          end
        end
      end

      default: begin
        state_d = StIdle;
        done_d  = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  state_legal_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {StIdle, StEncrypt, StDigest});
  // a result only ever comes out of a running operation
  out_valid_after_round_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o |-> $past(state_q) inside {StEncrypt, StDigest});

endmodule

`default_nettype wire

// File: source/scrmbl_top.sv
`default_nettype none

module scrmbl_top (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire scrmbl_pkg::scrmbl_cmd_e cmd_i,
  input  wire scrmbl_pkg::sel_t        sel_i,
  input  wire scrmbl_pkg::block_t      data_i,
  input  wire                          valid_i,
  output logic                         ready_o,
  output scrmbl_pkg::block_t           data_o,
  output logic                         valid_o
);

  import scrmbl_pkg::*;

  // steering from the controller into the datapath
  key_sel_e   key_sel;
  data_sel_e  data_sel;
  logic       key_en;
  logic       data_en;
  logic       shadow_en;
  logic       digest_en;
  logic       digest_init;
  logic       out_valid;
  round_idx_t round_idx;

  scrmbl_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_i         (cmd_i),
    .valid_i       (valid_i),
    .round_idx_i   (round_idx),
    .ready_o       (ready_o),
    .key_sel_o     (key_sel),
    .data_sel_o    (data_sel),
    .key_en_o      (key_en),
    .data_en_o     (data_en),
    .shadow_en_o   (shadow_en),
    .digest_en_o   (digest_en),
    .digest_init_o (digest_init),
    .out_valid_o   (out_valid)
  );

  scrmbl_datapath u_datapath (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .sel_i         (sel_i),
    .data_i        (data_i),
    .key_sel_i     (key_sel),
    .data_sel_i    (data_sel),
    .key_en_i      (key_en),
    .data_en_i     (data_en),
    .shadow_en_i   (shadow_en),
    .digest_en_i   (digest_en),
    .digest_init_i (digest_init),
    .out_valid_i   (out_valid),
    .round_idx_o   (round_idx),
    .data_o        (data_o)
  );

  // the output register is loaded exactly when the controller signals a result
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= out_valid;
    end
  end

endmodule

`default_nettype wire

// File: test/tb_present_model.svh
`ifndef TB_PRESENT_MODEL_SVH
`define TB_PRESENT_MODEL_SVH

// reference model of PRESENT-128 and of the digest on top of it
// it follows the cipher specification and shares no code with the RTL

// S-box as a packed table with entry 0 in the top nibble
localparam logic [63:0] sbox_table = 64'hc56b_90ad_3ef8_4712;

function automatic logic [3:0] sbox_lookup(input logic [3:0] x);
  return sbox_table[4*(15 - int'(x)) +: 4];
endfunction

// bit 4*j+k of the state moves to bit 16*k+j
function automatic block_t bit_perm(input block_t x);
  block_t y;
  y = '0;
  for (int j = 0; j < 16; j++) begin
    for (int k = 0; k < 4; k++) begin
      y[16*k + j] = x[4*j + k];
    end
  end
  return y;
endfunction

function automatic block_t present_encrypt(input block_t pt, input key_t key);
  block_t s;
  key_t   k;
  s = pt;
  k = key;
  for (int r = 1; r <= `SCRMBL_NUM_ROUNDS; r++) begin
    s = s ^ k[127:64];
    for (int n = 0; n < 16; n++) begin
      s[4*n +: 4] = sbox_lookup(s[4*n +: 4]);
    end
    s = bit_perm(s);
    // the 128-bit schedule rotates by 61 and substitutes the top byte
    k = {k[66:0], k[127:67]};
    k[127:124] = sbox_lookup(k[127:124]);
    k[123:120] = sbox_lookup(k[123:120]);
    k[66:62] = k[66:62] ^ 5'(r);
  end
  // round key 32 whitens the output
  return s ^ k[127:64];
endfunction

function automatic key_t table_key(input sel_t s);
  case (s)
    2'd0: return `SCRMBL_KEY_0;
    2'd1: return `SCRMBL_KEY_1;
    2'd2: return `SCRMBL_KEY_2;
    default: return `SCRMBL_KEY_3;
  endcase
endfunction

function automatic block_t digest_iv(input sel_t s);
  return (s == 2'd1) ? `SCRMBL_DIGEST_IV_1 : `SCRMBL_DIGEST_IV_0;
endfunction

function automatic key_t digest_const(input sel_t s);
  return (s == 2'd1) ? `SCRMBL_DIGEST_CONST_1 : `SCRMBL_DIGEST_CONST_0;
endfunction

// Davies-Meyer step, the later block forms the upper key half
function automatic block_t chain_block(input block_t state, input block_t first,
                                       input block_t second);
  return present_encrypt(state, {second, first}) ^ state;
endfunction

function automatic block_t finalize_state(input block_t state, input sel_t s);
  return present_encrypt(state, digest_const(s)) ^ state;
endfunction

`endif

// File: test/tb_scrmbl.sv
`default_nettype none

`include "scrmbl_cfg.svh"

module tb_scrmbl;

  import scrmbl_pkg::*;

  `include "tb_present_model.svh"

  localparam int num_enc = 200;
  localparam int num_pairs = 6;
  localparam int num_mixed = 100;
  // init, the message pairs and finalize
  localparam int digest_cmds = 2 + 2 * num_pairs;
  // the interleaved digest adds at most one encryption after each step but the last
  localparam int max_cmds = 1 + num_enc + 2 * digest_cmds + (digest_cmds - 1) + num_mixed;
  localparam int cycle_limit = 40 * max_cmds + 100;
  // the result shows up 33 falling edges after the one that saw the command accepted
  localparam int result_latency = 33;
  localparam block_t known_answer = 64'h96db_702a_2e69_00af;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  scrmbl_cmd_e cmd_i;
  sel_t        sel_i;
  block_t      data_i;
  logic        valid_i;
  logic        ready_o;
  block_t      data_o;
  logic        valid_o;

  logic [31:0] rng_state = 32'hec06;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          cycle_cnt = 0;
  int          mon_cycle = 0;
  int          pulse_cnt = 0;
  int          result_cmd_cnt = 0;

  // scoreboard state, expected results wait here with the cycle they are due
  block_t      exp_val[$];
  int          exp_due[$];
  block_t      shadow_m = '0;
  block_t      digest_m = '0;
  block_t      last_result = '0;
  block_t      msg[2*num_pairs];

  scrmbl_top scrmbl_top_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (cmd_i),
    .sel_i   (sel_i),
    .data_i  (data_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_o  (data_o),
    .valid_o (valid_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic block_t random_block();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, lo};
  endfunction

  // digest sets only exist for selector values 0 and 1
  function automatic sel_t pick_sel(input logic digest_set);
    logic [31:0] r;
    r = next_rand();
    return digest_set ? sel_t'(r[31]) : r[31:30];
  endfunction

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // scoreboard, sampled mid-cycle where every signal is settled

  task automatic expect_result(input block_t value);
    exp_val.push_back(value);
    exp_due.push_back(mon_cycle + result_latency);
    result_cmd_cnt++;
  endtask

  task automatic accept_command();
    case (cmd_i)
      CmdEncrypt: begin
        expect_result(present_encrypt(data_i, table_key(sel_i)));
      end
      CmdLoadShadow: begin
        shadow_m = data_i;
      end
      CmdDigestInit: begin
        digest_m = digest_iv(sel_i);
      end
      CmdDigest: begin
        digest_m = chain_block(digest_m, shadow_m, data_i);
        expect_result(digest_m);
      end
      CmdDigestFinalize: begin
        digest_m = finalize_state(digest_m, sel_i);
        expect_result(digest_m);
      end
      default: begin
      end
    endcase
  endtask

  always @(negedge clk_i) begin
    block_t expected;
    int     due;
    if (rst_ni) begin
      mon_cycle++;
      if (valid_o) begin
        pulse_cnt++;
        if (exp_due.size() == 0) begin
          err_cnt++;
          $display("valid_o pulsed at %0t although no result was outstanding", $time);
        end else begin
          expected = exp_val.pop_front();
          due = exp_due.pop_front();
          check_equal(64'(mon_cycle), 64'(due), "result latency");
          check_equal(data_o, expected, "result value");
        end
        last_result = data_o;
      end else begin
        check_equal(data_o, '0, "data_o while valid_o is low");
      end
      // the DUT is busy exactly while a result is outstanding
      check_equal(64'(ready_o), 64'(exp_due.size() == 0), "ready_o");
      if (valid_i && ready_o) begin
        accept_command();
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // driver

  // holds the command until the DUT takes it and returns after that edge
  task automatic send_command(input scrmbl_cmd_e cmd, input sel_t sel, input block_t data);
    logic taken;
    cmd_i   <= cmd;
    sel_i   <= sel;
    data_i  <= data;
    valid_i <= 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = ready_o;
      @(posedge clk_i);
    end
  endtask

  task automatic idle_bus();
    valid_i <= 1'b0;
  endtask

  task automatic wait_results();
    while (exp_due.size() != 0) begin
      @(posedge clk_i);
    end
  endtask

  task automatic maybe_encrypt(input logic enable);
    logic [31:0] r;
    r = next_rand();
    if (enable && r[31]) begin
      send_command(CmdEncrypt, pick_sel(1'b0), random_block());
    end
  endtask

  // one full digest over msg, optionally with encryptions slipped in between the steps
  task automatic run_digest(input logic interleave, input sel_t set_sel, output block_t result);
    send_command(CmdDigestInit, set_sel, random_block());
    maybe_encrypt(interleave);
    for (int i = 0; i < num_pairs; i++) begin
      send_command(CmdLoadShadow, pick_sel(1'b0), msg[2*i]);
      maybe_encrypt(interleave);
      send_command(CmdDigest, pick_sel(1'b0), msg[2*i+1]);
      maybe_encrypt(interleave);
    end
    send_command(CmdDigestFinalize, set_sel, random_block());
    idle_bus();
    wait_results();
    result = last_result;
  endtask

  initial begin
    block_t      plain_digest;
    block_t      mixed_digest;
    block_t      expected;
    sel_t        set_sel;
    logic [31:0] r;
    scrmbl_cmd_e cmd;

    rst_ni  <= 1'b0;
    valid_i <= 1'b0;
    cmd_i   <= CmdEncrypt;
    sel_i   <= '0;
    data_i  <= '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    // reset values and the published test vector
    @(negedge clk_i);
    check_equal(64'(ready_o), 64'd1, "ready_o after reset");
    check_equal(64'(valid_o), 64'd0, "valid_o after reset");
    check_equal(data_o, '0, "data_o after reset");
    check_equal(present_encrypt('0, table_key(2'd0)), known_answer, "model test vector");
    @(posedge clk_i);
    send_command(CmdEncrypt, 2'd0, '0);
    idle_bus();
    wait_results();
    check_equal(last_result, known_answer, "test vector from the DUT");

    // back to back encryptions, valid_i stays high while the DUT is busy
    for (int i = 0; i < num_enc; i++) begin
      send_command(CmdEncrypt, pick_sel(1'b0), random_block());
    end
    idle_bus();
    wait_results();

    // digest with the expected value worked out up front
    for (int i = 0; i < 2 * num_pairs; i++) begin
      msg[i] = random_block();
    end
    r = next_rand();
    set_sel = sel_t'(r[31]);
    expected = digest_iv(set_sel);
    for (int i = 0; i < num_pairs; i++) begin
      expected = chain_block(expected, msg[2*i], msg[2*i+1]);
    end
    expected = finalize_state(expected, set_sel);
    run_digest(1'b0, set_sel, plain_digest);
    check_equal(plain_digest, expected, "digest result");

    // same messages again with encryptions in between
    run_digest(1'b1, set_sel, mixed_digest);
    check_equal(mixed_digest, plain_digest, "digest with interleaved encryptions");

    // random command stream held on the bus while the DUT works
    for (int i = 0; i < num_mixed; i++) begin
      r = next_rand();
      cmd = scrmbl_cmd_e'(3'(r[31:16] % 16'd5));
      send_command(cmd, pick_sel(cmd inside {CmdDigestInit, CmdDigestFinalize}),
                   random_block());
    end
    idle_bus();
    wait_results();
    // a stray operation would still show up here
    repeat (40) @(posedge clk_i);
    check_equal(64'(pulse_cnt), 64'(result_cmd_cnt), "valid_o pulse count");

    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
+incdir+test
source/scrmbl_pkg.sv
source/present_round.sv
source/scrmbl_datapath.sv
source/scrmbl_ctrl.sv
source/scrmbl_top.sv
test/tb_scrmbl.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_scrmbl
RTL_TOP   = scrmbl_top
FILELIST  = build.f
RTL_SRCS  = source/scrmbl_pkg.sv source/present_round.sv source/scrmbl_datapath.sv \
            source/scrmbl_ctrl.sv source/scrmbl_top.sv
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall +incdir+source --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
